// File: hw/cmdLink_macros.svh
`ifndef CMD_LINK_MACROS_SVH
`define CMD_LINK_MACROS_SVH

// operand and accumulator width.
`define CMD_DATA_W 32

// log2 of the FIFO depth; one slot stays free to tell full from empty.
`define CMD_FIFO_DEPTH_LOG2 4

// flops per head synchronizer, counting the source-side register.
`define CMD_SYNC_STAGES 3

`endif

// File: hw/cmdLinkPkg.sv
`default_nettype none

`include "cmdLink_macros.svh"

package cmdLinkPkg;

    typedef enum logic [2:0] {
        opLoad  = 3'd0,
        opAdd   = 3'd1,
        opXor   = 3'd2,
        opClear = 3'd3,
        opRead  = 3'd4 // codes 5 to 7 are illegal.
    } opcodeT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [`CMD_DATA_W-1:0] operand;
    } cmdWordT;

    typedef struct packed {
        logic                   valid;
        logic                   illegal; // opcode outside the defined set.
        logic                   emit; // operation produces a result.
        opcodeT                 opcode;
        logic [`CMD_DATA_W-1:0] operand;
    } decodedOpT;

    typedef struct packed {
        logic [7:0]             tag; // wraps after 255.
        logic                   illegal;
        opcodeT                 opcode;
        logic [`CMD_DATA_W-1:0] value;
    } resultT;

endpackage

`default_nettype wire

// File: hw/synchronizer.sv
`default_nettype none

module synchronizer #(
    parameter int width  = 1,
    parameter int stages = 3
) (
    input  wire              inClk,
    input  wire  [width-1:0] dataIn,
    input  wire              outClk,
    output logic [width-1:0] dataOut
);

    logic [width-1:0] inReg;
    logic [width-1:0] syncRegs [stages-1];

    // launch from a flop so the crossing sees no source-side glitches.
    always_ff @(posedge inClk) begin
        inReg <= dataIn;
    end

    always_ff @(posedge outClk) begin
        syncRegs[0] <= inReg;
        for (int i = 1; i < stages - 1; i++) begin
            syncRegs[i] <= syncRegs[i-1];
        end
    end

    // multi-bit value here is only safe in simulation.
    assign dataOut = syncRegs[stages-2];

endmodule

`default_nettype wire

// File: hw/dualClockFifo.sv
`default_nettype none

`include "cmdLink_macros.svh"

module dualClockFifo (
    input  wire                              aclr,

    input  wire                              inClk,
    input  wire                              writeEnable,
    input  wire cmdLinkPkg::cmdWordT         dataIn,
    output logic                             wrFull,
    output logic [`CMD_FIFO_DEPTH_LOG2-1:0]  wrUsed,

    input  wire                              outClk,
    input  wire                              readEnable,
    output logic                             rdEmpty,
    output cmdLinkPkg::cmdWordT              dataOut,
    output logic [`CMD_FIFO_DEPTH_LOG2-1:0]  rdUsed
);

    import cmdLinkPkg::*;

    localparam int depthLog2 = `CMD_FIFO_DEPTH_LOG2;
    localparam int depth     = 1 << depthLog2;

    cmdWordT              memory [depth];
    logic [depthLog2-1:0] writeHead;
    logic [depthLog2-1:0] readHead;
    logic [depthLog2-1:0] writeHeadRdSync;
    logic [depthLog2-1:0] readHeadWrSync;
    logic                 doWrite;
    logic                 doRead;

    synchronizer #(
        .width  (depthLog2),
        .stages (`CMD_SYNC_STAGES)
    ) i_writeHeadSync (
        .inClk   (inClk),
        .dataIn  (writeHead),
        .outClk  (outClk),
        .dataOut (writeHeadRdSync)
    );

    synchronizer #(
        .width  (depthLog2),
        .stages (`CMD_SYNC_STAGES)
    ) i_readHeadSync (
        .inClk   (outClk),
        .dataIn  (readHead),
        .outClk  (inClk),
        .dataOut (readHeadWrSync)
    );

    assign wrUsed  = writeHead - readHeadWrSync; // modulo depth.
    assign rdUsed  = writeHeadRdSync - readHead;
    assign wrFull  = &wrUsed; // depth-1 words stored.
    assign rdEmpty = rdUsed == '0;
    assign doWrite = writeEnable && !wrFull;
    assign doRead  = readEnable && !rdEmpty;

    always_ff @(posedge inClk or posedge aclr) begin
        if (aclr) begin
            writeHead <= '0;
        end else if (doWrite) begin
            writeHead <= writeHead + 1'b1; // wraps.
        end
    end

    always_ff @(posedge inClk) begin
        if (doWrite) begin
            memory[writeHead] <= dataIn;
        end
    end

    always_ff @(posedge outClk or posedge aclr) begin
        if (aclr) begin
            readHead <= '0;
        end else if (doRead) begin
            readHead <= readHead + 1'b1;
        end
    end

    // registered read port, word appears the cycle after the pop.
    always_ff @(posedge outClk) begin
        dataOut <= memory[readHead];
    end

    aWriteHeldWhenFull : assert property (
        @(posedge inClk) disable iff (aclr) wrFull |=> writeHead == $past(writeHead)
    ) else $error("write head moved while the FIFO was full.");

    aReadHeldWhenEmpty : assert property (
        @(posedge outClk) disable iff (aclr) rdEmpty |=> readHead == $past(readHead)
    ) else $error("read head moved while the FIFO was empty.");

endmodule

`default_nettype wire

// File: hw/cmdDecode.sv
`default_nettype none

module cmdDecode (
    input  wire                      outClk,
    input  wire                      aclr,
    input  wire                      drainEnable,
    input  wire                      rdEmpty,
    input  wire cmdLinkPkg::cmdWordT fifoData,
    output logic                     readEnable,
    output cmdLinkPkg::decodedOpT    decodedOp
);

    import cmdLinkPkg::*;

    logic popPending; // fifoData holds a popped word this cycle.
    logic illegalCode;
    logic readCode;

    // pop whenever a word is available and the consumer allows it.
    assign readEnable = drainEnable && !rdEmpty;

    assign illegalCode = !(fifoData.opcode inside {opLoad, opAdd, opXor, opClear, opRead});
    assign readCode    = fifoData.opcode == opRead;

    always_ff @(posedge outClk or posedge aclr) begin
        if (aclr) begin
            popPending <= 1'b0;
            decodedOp  <= '0;
        end else begin
            popPending        <= readEnable;
            decodedOp.valid   <= popPending;
            decodedOp.illegal <= popPending && illegalCode;
            decodedOp.emit    <= popPending && readCode;
            decodedOp.opcode  <= fifoData.opcode;
            decodedOp.operand <= fifoData.operand;
        end
    end

    // one cycle for the registered FIFO read and one for decode.
    aDecodeAfterPop : assert property (
        @(posedge outClk) disable iff (aclr) readEnable |-> ##2 decodedOp.valid
    ) else $error("decoded operation missing two cycles after a pop.");

    aNoDecodeWithoutPop : assert property (
        @(posedge outClk) disable iff (aclr) decodedOp.valid |-> $past(readEnable, 2)
    ) else $error("decoded operation without a matching pop.");

endmodule

`default_nettype wire

// File: hw/accumExecute.sv
`default_nettype none

`include "cmdLink_macros.svh"

module accumExecute (
    input  wire                        outClk,
    input  wire                        aclr,
    input  wire cmdLinkPkg::decodedOpT decodedOp,
    output cmdLinkPkg::decodedOpT      execOp,
    output logic [`CMD_DATA_W-1:0]     execValue
);

    import cmdLinkPkg::*;

    logic [`CMD_DATA_W-1:0] accum;
    logic [`CMD_DATA_W-1:0] nextAccum;

    always_comb begin
        nextAccum = accum;
        if (decodedOp.valid && !decodedOp.illegal) begin
            case (decodedOp.opcode)
                opLoad:  nextAccum = decodedOp.operand;
                opAdd:   nextAccum = accum + decodedOp.operand; // wraps.
                opXor:   nextAccum = accum ^ decodedOp.operand;
                opClear: nextAccum = '0;
                default: nextAccum = accum; // opRead keeps the value.
            endcase
        end
    end

    always_ff @(posedge outClk or posedge aclr) begin
        if (aclr) begin
            accum  <= '0;
            execOp <= '0;
        end else begin
            accum  <= nextAccum;
            execOp <= decodedOp;
        end
    end

    // a read sees the accumulator as left by earlier commands.
    always_ff @(posedge outClk) begin
        execValue <= decodedOp.illegal ? decodedOp.operand : nextAccum;
    end

    aIllegalKeepsAccum : assert property (
        @(posedge outClk) disable iff (aclr)
        (execOp.valid && execOp.illegal) |-> accum == $past(accum)
    ) else $error("illegal command changed the accumulator.");

endmodule

`default_nettype wire

// File: hw/resultPack.sv
`default_nettype none

`include "cmdLink_macros.svh"

module resultPack (
    input  wire                        outClk,
    input  wire                        aclr,
    input  wire cmdLinkPkg::decodedOpT execOp,
    input  wire [`CMD_DATA_W-1:0]      execValue,
    output logic                       resValid,
    output cmdLinkPkg::resultT         result,
    output logic [7:0]                 illegalCount
);

    import cmdLinkPkg::*;

    logic [7:0] seqTag; // tag of the next result.
    logic       fire;

    assign fire = execOp.valid && (execOp.emit || execOp.illegal);

    always_ff @(posedge outClk or posedge aclr) begin
        if (aclr) begin
            resValid     <= 1'b0;
            seqTag       <= '0;
            illegalCount <= '0;
        end else begin
            resValid <= fire;
            if (fire) begin
                seqTag <= seqTag + 8'd1;
            end
            if (fire && execOp.illegal && illegalCount != 8'hff) begin
                illegalCount <= illegalCount + 8'd1; // saturates.
            end
        end
    end

    always_ff @(posedge outClk) begin
        if (fire) begin
            result.tag     <= seqTag;
            result.illegal <= execOp.illegal;
            result.opcode  <= execOp.opcode;
            result.value   <= execValue;
        end
    end

    aBackToBackEmits : assert property (
        @(posedge outClk) disable iff (aclr)
        (resValid ##1 resValid) |->
            (($past(result.illegal) || $past(result.opcode) == opRead) &&
             (result.illegal || result.opcode == opRead))
    ) else $error("consecutive result strobes without two emitting operations.");

    aTagStep : assert property (
        @(posedge outClk) disable iff (aclr)
        (resValid ##1 resValid) |-> result.tag == $past(result.tag) + 8'd1
    ) else $error("result tag skipped between consecutive results.");

endmodule

`default_nettype wire

// File: hw/cmdLinkTop.sv
`default_nettype none

`include "cmdLink_macros.svh"

module cmdLinkTop (
    input  wire                                inClk,
    input  wire                                outClk,
    input  wire                                aclr,
    input  wire                                cmdWrite,
    input  wire cmdLinkPkg::cmdWordT           cmdIn,
    output wire                                cmdFull,
    output wire [`CMD_FIFO_DEPTH_LOG2-1:0]     cmdUsed,
    input  wire                                drainEnable,
    output wire                                resValid,
    output wire cmdLinkPkg::resultT            result,
    output wire [7:0]                          illegalCount
);

    import cmdLinkPkg::*;

    wire                    rdEmpty;
    wire                    readEnable;
    wire cmdWordT           fifoData;
    wire decodedOpT         decodedOp;
    wire decodedOpT         execOp;
    wire [`CMD_DATA_W-1:0]  execValue;

    dualClockFifo i_dualClockFifo (
        .aclr        (aclr),
        .inClk       (inClk),
        .writeEnable (cmdWrite),
        .dataIn      (cmdIn),
        .wrFull      (cmdFull),
        .wrUsed      (cmdUsed),
        .outClk      (outClk),
        .readEnable  (readEnable),
        .rdEmpty     (rdEmpty),
        .dataOut     (fifoData),
        .rdUsed      ()
    );

    cmdDecode i_cmdDecode (
        .outClk      (outClk),
        .aclr        (aclr),
        .drainEnable (drainEnable),
        .rdEmpty     (rdEmpty),
        .fifoData    (fifoData),
        .readEnable  (readEnable),
        .decodedOp   (decodedOp)
    );

    accumExecute i_accumExecute (
        .outClk    (outClk),
        .aclr      (aclr),
        .decodedOp (decodedOp),
        .execOp    (execOp),
        .execValue (execValue)
    );

    resultPack i_resultPack (
        .outClk       (outClk),
        .aclr         (aclr),
        .execOp       (execOp),
        .execValue    (execValue),
        .resValid     (resValid),
        .result       (result),
        .illegalCount (illegalCount)
    );

endmodule

`default_nettype wire

// File: dv/cmdLinkTb.sv
`default_nettype none

`include "cmdLink_macros.svh"

module cmdLinkTb;

    import cmdLinkPkg::*;

    localparam int directedCount = 43; // arithmetic, illegal and fill phases.
    localparam int randomCount   = 600;
    localparam int totalCommands = directedCount + randomCount + 1;
    localparam int cycleLimit    = 40 * totalCommands + 500;

    logic                             inClk = 1'b0;
    logic                             outClk = 1'b0;
    logic                             aclr;
    logic                             cmdWrite;
    cmdWordT                          cmdIn;
    logic                             cmdFull;
    logic [`CMD_FIFO_DEPTH_LOG2-1:0]  cmdUsed;
    logic                             drainEnable;
    logic                             resValid;
    resultT                           result;
    logic [7:0]                       illegalCount;

    resultT                 expQueue [$];
    resultT                 expHead;
    logic                   expEmpty = 1'b1;
    logic [`CMD_DATA_W-1:0] modelAccum = '0;
    logic [7:0]             modelTag = '0;
    logic [7:0]             modelIllegal = '0;
    logic                   lastAccepted;
    logic                   anyWritten = 1'b0;
    int                     resultTotal = 0;
    int                     valueErrors = 0;
    int                     otherErrors = 0;
    int                     cycleCount = 0;
    string                  testName = "reset";

    cmdLinkTop i_cmdLinkTop (
        .inClk        (inClk),
        .outClk       (outClk),
        .aclr         (aclr),
        .cmdWrite     (cmdWrite),
        .cmdIn        (cmdIn),
        .cmdFull      (cmdFull),
        .cmdUsed      (cmdUsed),
        .drainEnable  (drainEnable),
        .resValid     (resValid),
        .result       (result),
        .illegalCount (illegalCount)
    );

    always #5 outClk = ~outClk;
    always #7 inClk = ~inClk; // unrelated to outClk.

    function automatic void refreshHead();
        expEmpty = expQueue.size() == 0;
        expHead  = expEmpty ? '0 : expQueue[0];
    endfunction

    function automatic void pushExpected(input logic illegal, input logic [2:0] code,
                                         input logic [`CMD_DATA_W-1:0] value);
        resultT rec;
        rec.tag     = modelTag;
        rec.illegal = illegal;
        rec.opcode  = opcodeT'(code);
        rec.value   = value;
        expQueue.push_back(rec);
        modelTag = modelTag + 8'd1; // wraps like the hardware tag.
        resultTotal++;
        refreshHead();
    endfunction

    // model of one accepted command, in FIFO order.
    function automatic void applyToModel(input logic [2:0] code,
                                         input logic [`CMD_DATA_W-1:0] operand);
        case (code)
            opLoad:  modelAccum = operand;
            opAdd:   modelAccum = modelAccum + operand;
            opXor:   modelAccum = modelAccum ^ operand;
            opClear: modelAccum = '0;
            opRead:  pushExpected(1'b0, code, modelAccum);
            default: begin
                pushExpected(1'b1, code, operand);
                if (modelIllegal != 8'hff) begin
                    modelIllegal = modelIllegal + 8'd1;
                end
            end
        endcase
    endfunction

    // cmdFull cannot change between this edge and the write edge.
    task automatic sendCommand(input logic [2:0] code, input logic [`CMD_DATA_W-1:0] operand);
        @(negedge inClk);
        anyWritten   = 1'b1;
        cmdWrite     = 1'b1;
        cmdIn        = {code, operand};
        lastAccepted = !cmdFull;
        if (lastAccepted) begin
            applyToModel(code, operand);
        end
    endtask

    task automatic stopWriting();
        @(negedge inClk);
        cmdWrite = 1'b0;
    endtask

    task automatic waitForResults();
        stopWriting();
        while (expQueue.size() != 0) begin
            @(negedge outClk);
        end
        repeat (6) @(negedge outClk); // trailing non-emitting commands.
    endtask

    always @(posedge outClk) begin
        if (!aclr && resValid && expQueue.size() > 0) begin
            void'(expQueue.pop_front());
            refreshHead();
        end
    end

    always @(posedge outClk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d outClk cycles.", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    aResultExpected : assert property (
        @(posedge outClk) disable iff (aclr) resValid |-> !expEmpty
    ) else begin
        otherErrors++;
        $display("%s: result strobe with no command outstanding.", testName);
    end

    aResultMatches : assert property (
        @(posedge outClk) disable iff (aclr) (resValid && !expEmpty) |-> result == expHead
    ) else begin
        valueErrors++;
        $display("ERROR %s: expected %h, actual %h", testName, $sampled(expHead),
                 $sampled(result));
    end

    // pipeline is four cycles deep behind readEnable.
    aNoResultWhileHeld : assert property (
        @(posedge outClk) disable iff (aclr) (!drainEnable) [*5] |-> !resValid
    ) else begin
        otherErrors++;
        $display("%s: result appeared while drainEnable was held low.", testName);
    end

    aQuietAfterReset : assert property (
        @(posedge outClk) disable iff (aclr) !anyWritten |-> (!resValid && !cmdFull)
    ) else begin
        otherErrors++;
        $display("%s: activity on resValid or cmdFull before any write.", testName);
    end

    initial begin
        int acceptedCount;
        void'($urandom(23193));
        aclr        = 1'b1;
        cmdWrite    = 1'b0;
        cmdIn       = '0;
        drainEnable = 1'b0;
        repeat (16) @(posedge outClk);
        @(negedge outClk);
        aclr        = 1'b0;
        drainEnable = 1'b1;

        repeat (20) @(negedge outClk);
        assert (illegalCount == 8'd0) else begin
            valueErrors++;
            $display("ERROR %s: expected %h, actual %h", testName, 8'd0, illegalCount);
        end

        testName = "arithmetic";
        sendCommand(opLoad, 32'h1234_5678);
        sendCommand(opRead, 32'h0);
        sendCommand(opAdd, 32'h1111_1111);
        sendCommand(opRead, 32'h0);
        sendCommand(opLoad, 32'hffff_fff0);
        sendCommand(opAdd, 32'h0000_0025); // carries out of bit 31.
        sendCommand(opRead, 32'h0);
        sendCommand(opXor, 32'ha5a5_a5a5);
        sendCommand(opRead, 32'h0);
        sendCommand(opClear, 32'hdead_beef);
        sendCommand(opRead, 32'h0);
        sendCommand(opAdd, 32'h0000_0007);
        sendCommand(opXor, 32'h0000_0003);
        sendCommand(opAdd, 32'hffff_ffff);
        sendCommand(opRead, 32'h0);
        waitForResults();

        testName = "illegal codes";
        sendCommand(opLoad, 32'h0000_0055);
        sendCommand(3'd5, 32'hdead_0005);
        sendCommand(3'd6, 32'hdead_0006);
        sendCommand(3'd7, 32'hdead_0007);
        sendCommand(opRead, 32'h0);
        sendCommand(opAdd, 32'h0000_0001);
        sendCommand(3'd7, 32'hbeef_0007);
        sendCommand(opRead, 32'h0);
        waitForResults();

        testName = "full FIFO";
        while (cmdUsed != 0) begin
            @(negedge inClk);
        end
        @(negedge outClk);
        drainEnable = 1'b0;
        repeat (8) @(negedge outClk);
        acceptedCount = 0;
        for (int i = 0; i < 20; i++) begin
            sendCommand((i % 3 == 2) ? opRead : opAdd, i + 1);
            if (lastAccepted) begin
                acceptedCount++;
            end
        end
        stopWriting();
        assert (cmdFull && acceptedCount == 15) else begin
            otherErrors++;
            $display("%s: cmdFull not raised after exactly 15 accepted writes (%0d).",
                     testName, acceptedCount);
        end
        assert (cmdUsed == 4'd15) else begin
            valueErrors++;
            $display("ERROR %s: expected %0d, actual %0d", testName, 15, cmdUsed);
        end
        repeat (30) @(negedge outClk);

        testName = "drain after fill";
        @(negedge outClk);
        drainEnable = 1'b1;
        waitForResults();
        while (cmdFull) begin
            @(negedge inClk);
        end

        testName = "random";
        for (int i = 0; i < randomCount; i++) begin
            sendCommand(3'($urandom % 8), $urandom);
        end
        sendCommand(opRead, 32'h0);
        waitForResults();
        assert (resultTotal > 256) else begin
            otherErrors++;
            $display("%s: too few results (%0d) for the tag to wrap.", testName, resultTotal);
        end

        testName = "final";
        assert (illegalCount == modelIllegal) else begin
            valueErrors++;
            $display("ERROR %s: expected %h, actual %h", testName, modelIllegal, illegalCount);
        end
        assert (expQueue.size() == 0) else begin
            otherErrors++;
            $display("%s: %0d expected results never arrived.", testName, expQueue.size());
        end

        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/cmdLinkPkg.sv
hw/synchronizer.sv
hw/dualClockFifo.sv
hw/cmdDecode.sv
hw/accumExecute.sv
hw/resultPack.sv
hw/cmdLinkTop.sv
dv/cmdLinkTb.sv
